//--- design/fpslice_params.svh
`ifndef FPSLICE_PARAMS_SVH
`define FPSLICE_PARAMS_SVH

// ---------------------------------------------------------------------------
// Slice dimensions
// ---------------------------------------------------------------------------

// Datapath width of the slice, one FP32 value
`define FPSLICE_WIDTH 32

// Number of SIMD lanes, set by the narrowest format (FP8)
`define FPSLICE_NUM_LANES 4

// Width of the tag carried beside each operation
`define FPSLICE_TAG_WIDTH 4

// ---------------------------------------------------------------------------
// Pipeline
// ---------------------------------------------------------------------------

// Register stages per lane, which is also the input to output latency
`define FPSLICE_PIPE_REGS 2

`endif

//--- design/fpslice_pkg.sv
`include "fpslice_params.svh"

package fpslice_pkg;

  localparam int unsigned NUM_FP_FORMATS = 3;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_format_e;

  // One bit per fp_format_e value
  typedef logic [NUM_FP_FORMATS-1:0] fmt_mask_t;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } operation_e;

  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // Input bundle of the slice
  typedef struct packed {
    logic [`FPSLICE_WIDTH-1:0]     op_a;
    logic [`FPSLICE_WIDTH-1:0]     op_b;
    operation_e                    op;
    fp_format_e                    fmt;
    logic                          vectorial;
    logic [`FPSLICE_NUM_LANES-1:0] mask;
    logic [`FPSLICE_TAG_WIDTH-1:0] tag;
  } slice_req_t;

  typedef struct packed {
    logic [`FPSLICE_WIDTH-1:0] result; // Zero-extended above the lane width
    status_t                   status;
  } lane_out_t;

  // Per-operation info that travels beside lane 0
  typedef struct packed {
    fp_format_e                    fmt;
    logic                          vectorial;
    logic [`FPSLICE_NUM_LANES-1:0] mask;
    logic [`FPSLICE_TAG_WIDTH-1:0] tag;
  } sideband_t;

  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    case (fmt)
      FP16, FP8: return 5;
      default:   return 8;
    endcase
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP16:    return 10;
      FP8:     return 2;
      default: return 23;
    endcase
  endfunction

  // Formats whose segment for this lane index still fits in the datapath
  function automatic fmt_mask_t lane_formats(int unsigned lane);
    fmt_mask_t served;
    for (int unsigned f = 0; f < NUM_FP_FORMATS; f++) begin
      served[f] = ((lane + 1) * fp_width(fp_format_e'(f))) <= `FPSLICE_WIDTH;
    end
    return served;
  endfunction

  function automatic int unsigned max_fp_width(fmt_mask_t formats);
    int unsigned width;
    width = 0;
    for (int unsigned f = 0; f < NUM_FP_FORMATS; f++) begin
      if (formats[f] && fp_width(fp_format_e'(f)) > width) begin
        width = fp_width(fp_format_e'(f));
      end
    end
    return width;
  endfunction

  // Lowest-index format present in the mask
  function automatic fp_format_e first_format(fmt_mask_t formats);
    fp_format_e fmt;
    fmt = FP32;
    for (int f = NUM_FP_FORMATS - 1; f >= 0; f--) begin
      if (formats[f]) begin
        fmt = fp_format_e'(f);
      end
    end
    return fmt;
  endfunction

endpackage

//--- design/fp_sgnj_minmax.sv
module fp_sgnj_minmax import fpslice_pkg::*; #(
  parameter int unsigned LaneWidth   = 32,
  parameter fmt_mask_t   LaneFormats = '1
) (
  input  logic [LaneWidth-1:0] a_i,
  input  logic [LaneWidth-1:0] b_i,
  input  operation_e           op_i,
  input  fp_format_e           fmt_i,
  output logic [LaneWidth-1:0] result_o,
  output status_t              status_o
);

  logic [LaneWidth-1:0]      fmt_result [NUM_FP_FORMATS];
  logic [NUM_FP_FORMATS-1:0] fmt_nv;

  // ---------------------------------------------------------------------------
  // One datapath per format the lane serves
  // ---------------------------------------------------------------------------
  for (genvar f = 0; f < NUM_FP_FORMATS; f++) begin : gen_fmt
    localparam fp_format_e  FMT = fp_format_e'(f);
    localparam int unsigned FW  = fp_width(FMT);
    localparam int unsigned EB  = exp_bits(FMT);
    localparam int unsigned MB  = man_bits(FMT);

    if (LaneFormats[f] && (FW <= LaneWidth)) begin : gen_active
      logic [FW-1:0] a;
      logic [FW-1:0] b;
      logic [FW-1:0] res;
      logic [FW-1:0] qnan;
      logic          a_nan;
      logic          b_nan;
      logic          a_snan;
      logic          b_snan;
      logic          a_lt_b;

      assign a    = a_i[FW-1:0]; // Upper bits belong to other lanes
      assign b    = b_i[FW-1:0];
      assign qnan = {1'b0, {EB{1'b1}}, 1'b1, {(MB-1){1'b0}}};

      // All-ones exponent with a nonzero mantissa
      assign a_nan  = (&a[FW-2 -: EB]) && (|a[MB-1:0]);
      assign b_nan  = (&b[FW-2 -: EB]) && (|b[MB-1:0]);
      assign a_snan = a_nan && !a[MB-1]; // Quiet bit is the mantissa MSB
      assign b_snan = b_nan && !b[MB-1];

      // Sign-magnitude ordering where -0 counts below +0
      always_comb begin : order
        if (a[FW-1] != b[FW-1]) begin
          a_lt_b = a[FW-1];
        end else if (a[FW-1]) begin
          a_lt_b = a[FW-2:0] > b[FW-2:0]; // Both negative
        end else begin
          a_lt_b = a[FW-2:0] < b[FW-2:0];
        end
      end

      always_comb begin : op_sel
        res = a;
        unique case (op_i)
          OP_SGNJ:  res = {b[FW-1], a[FW-2:0]};
          OP_SGNJN: res = {~b[FW-1], a[FW-2:0]};
          OP_SGNJX: res = {a[FW-1] ^ b[FW-1], a[FW-2:0]};
          OP_MIN, OP_MAX: begin
            if (a_nan && b_nan) begin
              res = qnan;
            end else if (a_nan) begin
              res = b;
            end else if (b_nan) begin
              res = a;
            end else begin
              res = ((op_i == OP_MIN) == a_lt_b) ? a : b;
            end
          end
          default: res = a;
        endcase
      end

      assign fmt_result[f] = LaneWidth'(res);
      assign fmt_nv[f]     = ((op_i == OP_MIN) || (op_i == OP_MAX)) && (a_snan || b_snan);
    end else begin : gen_unused
      assign fmt_result[f] = '0;
      assign fmt_nv[f]     = 1'b0;
    end
  end

  always_comb begin : out_sel
    result_o = '0;
    status_o = '0; // Only nv can be raised here
    if (int'(fmt_i) < NUM_FP_FORMATS) begin
      result_o    = fmt_result[fmt_i];
      status_o.nv = fmt_nv[fmt_i];
    end
  end

endmodule

//--- design/fpslice_pipe.sv
module fpslice_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned NumRegs   = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o,
  output logic     busy_o
);

  // Index i is the view after i register stages
  payload_t           stage_data [0:NumRegs];
  logic [0:NumRegs]   stage_valid;
  logic [0:NumRegs]   stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    payload_t data_q;
    logic     valid_q;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_data[i+1]  = data_q;
    assign stage_valid[i+1] = valid_q;
  end

  assign stage_ready[NumRegs] = out_ready_i; // Driven from downstream

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[NumRegs];
  assign data_o      = stage_data[NumRegs];

  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

  // A stalled head stays put until taken or flushed
  a_head_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(data_o));

endmodule

//--- design/fpslice_lane.sv
`include "fpslice_params.svh"

module fpslice_lane import fpslice_pkg::*; #(
  parameter int unsigned LaneIndex   = 0,
  parameter int unsigned LaneWidth   = 32,
  parameter fmt_mask_t   LaneFormats = '1
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       flush_i,
  input  slice_req_t req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output lane_out_t  lane_o,
  output logic       busy_o
);

  localparam fp_format_e FALLBACK_FMT = first_format(LaneFormats);

  logic [`FPSLICE_WIDTH-1:0] a_shifted;
  logic [`FPSLICE_WIDTH-1:0] b_shifted;
  fp_format_e                unit_fmt;
  logic [LaneWidth-1:0]      unit_result;
  status_t                   unit_status;
  lane_out_t                 lane_d;

  // Move this lane's segment down to bit 0
  assign a_shifted = req_i.op_a >> (LaneIndex * fp_width(req_i.fmt));
  assign b_shifted = req_i.op_b >> (LaneIndex * fp_width(req_i.fmt));

  // Keep the unit in range for formats that never arrive with a valid
  assign unit_fmt = LaneFormats[req_i.fmt] ? req_i.fmt : FALLBACK_FMT;

  fp_sgnj_minmax #(
    .LaneWidth   (LaneWidth),
    .LaneFormats (LaneFormats)
  ) u_sgnj_minmax (
    .a_i      (a_shifted[LaneWidth-1:0]),
    .b_i      (b_shifted[LaneWidth-1:0]),
    .op_i     (req_i.op),
    .fmt_i    (unit_fmt),
    .result_o (unit_result),
    .status_o (unit_status)
  );

  always_comb begin : pack_lane
    lane_d                          = '0;
    lane_d.result[LaneWidth-1:0]    = unit_result;
    lane_d.status                   = unit_status;
  end

  fpslice_pipe #(
    .payload_t (lane_out_t),
    .NumRegs   (`FPSLICE_PIPE_REGS)
  ) u_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (lane_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (lane_o),
    .busy_o      (busy_o)
  );

  // A valid operation must come in a format this lane was built for
  a_fmt_served: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i |-> LaneFormats[req_i.fmt]);

endmodule

//--- design/fpslice_result_pack.sv
`include "fpslice_params.svh"

module fpslice_result_pack import fpslice_pkg::*; (
  input  lane_out_t [`FPSLICE_NUM_LANES-1:0] lanes_i,
  input  logic [`FPSLICE_NUM_LANES-1:0]      lane_valid_i,
  input  fp_format_e                         fmt_i,
  input  logic [`FPSLICE_NUM_LANES-1:0]      mask_i,
  output logic [`FPSLICE_WIDTH-1:0]          result_o,
  output status_t                            status_o
);

  localparam int unsigned WIDTH     = `FPSLICE_WIDTH;
  localparam int unsigned NUM_LANES = `FPSLICE_NUM_LANES;

  logic [WIDTH-1:0] fmt_result [NUM_FP_FORMATS];

  // ---------------------------------------------------------------------------
  // Result assembly per format
  // ---------------------------------------------------------------------------
  for (genvar f = 0; f < NUM_FP_FORMATS; f++) begin : gen_fmt
    localparam int unsigned FW      = fp_width(fp_format_e'(f));
    localparam int unsigned NUM_SEG = (WIDTH / FW < NUM_LANES) ? WIDTH / FW : NUM_LANES;

    for (genvar s = 0; s < NUM_SEG; s++) begin : gen_seg
      // Idle lanes are NaN-boxed
      assign fmt_result[f][s*FW +: FW] = lane_valid_i[s] ? lanes_i[s].result[FW-1:0] : '1;
    end

    if (NUM_SEG * FW < WIDTH) begin : gen_box
      assign fmt_result[f][WIDTH-1:NUM_SEG*FW] = '1;
    end
  end

  assign result_o = (int'(fmt_i) < NUM_FP_FORMATS) ? fmt_result[fmt_i] : '1;

  // Only lanes that ran and are enabled by the mask raise flags
  always_comb begin : status_collapse
    status_o = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_valid_i[l] && mask_i[l]) begin
        status_o = status_o | lanes_i[l].status;
      end
    end
  end

endmodule

//--- design/fpslice_top.sv
`include "fpslice_params.svh"

module fpslice_top import fpslice_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,
  input  slice_req_t                    req_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  output logic [`FPSLICE_WIDTH-1:0]     result_o,
  output status_t                       status_o,
  output logic [`FPSLICE_TAG_WIDTH-1:0] tag_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  localparam int unsigned NUM_LANES = `FPSLICE_NUM_LANES;

  logic [NUM_LANES-1:0]      lane_in_valid;
  logic [NUM_LANES-1:0]      lane_in_ready;
  logic [NUM_LANES-1:0]      lane_out_valid;
  logic [NUM_LANES-1:0]      lane_out_ready;
  logic [NUM_LANES-1:0]      lane_used;   // Lane takes part in the head operation
  logic [NUM_LANES-1:0]      lane_active; // Lane result belongs to the head
  logic [NUM_LANES-1:0]      lane_busy;
  lane_out_t [NUM_LANES-1:0] lane_out;

  sideband_t sb_in;
  sideband_t sb_out;
  logic      sb_in_ready;
  logic      sb_busy;

  // ---------------------------------------------------------------------------
  // Lanes
  // ---------------------------------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    localparam fmt_mask_t   LANE_FORMATS = lane_formats(l);
    localparam int unsigned LANE_WIDTH   = max_fp_width(LANE_FORMATS);

    // Upper lanes only run vectorial operations in a format they can hold, and only
    // on the edge where lane 0 takes the operation as well
    assign lane_in_valid[l] = in_valid_i &
                              ((l == 0) |
                               (lane_in_ready[0] & req_i.vectorial & LANE_FORMATS[req_i.fmt]));

    // An upper lane only carries a subset of the items, so it is popped only when
    // the head operation actually used it
    assign lane_used[l]      = (l == 0) | (sb_out.vectorial & LANE_FORMATS[sb_out.fmt]);
    assign lane_out_ready[l] = out_ready_i & lane_used[l];
    assign lane_active[l]    = lane_out_valid[l] & lane_used[l];

    fpslice_lane #(
      .LaneIndex   (l),
      .LaneWidth   (LANE_WIDTH),
      .LaneFormats (LANE_FORMATS)
    ) u_lane (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush_i),
      .req_i       (req_i),
      .in_valid_i  (lane_in_valid[l]),
      .in_ready_o  (lane_in_ready[l]),
      .out_valid_o (lane_out_valid[l]),
      .out_ready_i (lane_out_ready[l]),
      .lane_o      (lane_out[l]),
      .busy_o      (lane_busy[l])
    );
  end

  // ---------------------------------------------------------------------------
  // Sideband with the same handshake as lane 0
  // ---------------------------------------------------------------------------
  assign sb_in = '{
    fmt:       req_i.fmt,
    vectorial: req_i.vectorial,
    mask:      req_i.mask,
    tag:       req_i.tag
  };

  fpslice_pipe #(
    .payload_t (sideband_t),
    .NumRegs   (`FPSLICE_PIPE_REGS)
  ) u_sideband_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (sb_in_ready),
    .data_i      (sb_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (sb_out),
    .busy_o      (sb_busy)
  );

  // ---------------------------------------------------------------------------
  // Output side
  // ---------------------------------------------------------------------------
  fpslice_result_pack u_result_pack (
    .lanes_i      (lane_out),
    .lane_valid_i (lane_active),
    .fmt_i        (sb_out.fmt),
    .mask_i       (sb_out.mask),
    .result_o     (result_o),
    .status_o     (status_o)
  );

  assign in_ready_o = lane_in_ready[0]; // Lane 0 sees every operation
  assign tag_o      = sb_out.tag;
  assign busy_o     = (|lane_busy) | sb_busy;

  // Sideband and lane 0 hold the same items, so they fill and drain together
  a_sideband_lockstep: assert property (@(posedge clk_i) disable iff (rst_i)
    lane_in_ready[0] == sb_in_ready);

  // Upper lanes never hold more than lane 0 and must not throttle the input
  a_upper_lanes_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    lane_in_ready[0] |-> &lane_in_ready);

endmodule

//--- testbench/fpslice_tests.svh
`ifndef FPSLICE_TESTS_SVH
`define FPSLICE_TESTS_SVH

// --------------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------------

task automatic minmax_fp32_scalar();
  int start_errs;
  start_errs = err_count;
  if (out_valid_o !== 1'b0) begin
    $display("error at %0t: out_valid_o is %b, expected 0", $time, out_valid_o);
    err_count++;
  end
  if (busy_o !== 1'b0) begin
    $display("error at %0t: busy_o is %b, expected 0", $time, busy_o);
    err_count++;
  end
  if (in_ready_o !== 1'b1) begin
    $display("error at %0t: in_ready_o is %b, expected 1", $time, in_ready_o);
    err_count++;
  end
  push_op(make_req(32'h4040_0000, 32'hbfc0_0000, OP_MIN, FP32, 1'b0, 4'b0001));
  push_op(make_req(32'h4040_0000, 32'hbfc0_0000, OP_MAX, FP32, 1'b0, 4'b0001));
  push_op(make_req(32'h8000_0000, 32'h0000_0000, OP_MIN, FP32, 1'b0, 4'b0001)); // Signed zeros
  push_op(make_req(32'h0000_0000, 32'h8000_0000, OP_MAX, FP32, 1'b0, 4'b0001));
  push_op(make_req(32'h7fc0_0000, 32'h3f80_0000, OP_MIN, FP32, 1'b0, 4'b0001));
  push_op(make_req(32'hffc0_1234, 32'h7f80_0001, OP_MAX, FP32, 1'b0, 4'b0001));
  push_op(make_req(32'h7f80_0001, 32'h4000_0000, OP_MIN, FP32, 1'b0, 4'b0001)); // sNaN
  idle_input();
  wait_drain();
  report_test("minmax_fp32_scalar", start_errs);
endtask

task automatic sgnj_narrow_scalar();
  int         start_errs;
  fp_format_e fmt;
  start_errs = err_count;
  for (int f = 0; f < 2; f++) begin
    fmt = (f == 0) ? FP16 : FP8;
    for (int op = 0; op < 3; op++) begin
      repeat (3) begin
        push_op(make_req($urandom, $urandom, operation_e'(3'(op)), fmt, 1'b0, 4'b1111));
      end
    end
  end
  idle_input();
  wait_drain();
  report_test("sgnj_narrow_scalar", start_errs);
endtask

task automatic vector_minmax_snan();
  int          start_errs;
  logic [31:0] a;
  logic [31:0] b;
  start_errs = err_count;
  repeat (3) begin
    a          = $urandom;
    b          = $urandom;
    a[23:16]   = 8'h7d; // FP8 signaling NaN in lane 2
    push_op(make_req(a, b, OP_MIN, FP8, 1'b1, 4'b1111));
    push_op(make_req(a, b, OP_MIN, FP8, 1'b1, 4'b1011));
    a          = $urandom;
    b          = $urandom;
    a[31:16]   = 16'h7c01; // FP16 signaling NaN in lane 1
    push_op(make_req(a, b, OP_MIN, FP16, 1'b1, 4'b0011));
    push_op(make_req(a, b, OP_MAX, FP16, 1'b1, 4'b0001));
  end
  idle_input();
  wait_drain();
  report_test("vector_minmax_snan", start_errs);
endtask

task automatic stream_backpressure();
  int start_errs;
  int start_outs;
  int waited;
  bit stream_done;
  start_errs  = err_count;
  start_outs  = out_count;
  stream_done = 1'b0;
  @(negedge clk_i);
  out_ready_i = 1'b0;
  fork
    begin
      for (int i = 0; i < 8; i++) begin
        push_op(make_req($urandom, $urandom, operation_e'(3'($urandom % 5)),
                         fp_format_e'(2'($urandom % 3)), 1'($urandom), 4'($urandom)));
      end
      idle_input();
      stream_done = 1'b1;
    end
    begin
      repeat (6) @(negedge clk_i); // Let the pipeline fill up
      waited = 0;
      while ((!stream_done || exp_q.size() > 0) && waited < 4 * WAIT_LIMIT) begin
        @(negedge clk_i);
        out_ready_i = 1'($urandom);
        waited++;
      end
      out_ready_i = 1'b1;
    end
  join
  wait_drain();
  if (out_count - start_outs != 8) begin
    $display("error at %0t: output count is %0d, expected 8", $time, out_count - start_outs);
    err_count++;
  end
  report_test("stream_backpressure", start_errs);
endtask

task automatic latency_check();
  int   start_errs;
  int   cycles;
  logic seen;
  start_errs = err_count;
  repeat (3) begin
    push_op(make_req($urandom, $urandom, OP_MAX, FP16, 1'b1, 4'b0011));
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
      #1;
      cycles++;
      seen = out_valid_o;
    end
    if (!seen) begin
      $display("timeout at %0t: out_valid_o never rose", $time);
      err_count++;
    end else if (cycles != `FPSLICE_PIPE_REGS) begin
      $display("error at %0t: out_valid_o latency is %0d, expected %0d",
               $time, cycles, `FPSLICE_PIPE_REGS);
      err_count++;
    end
    wait_drain();
  end
  report_test("latency_check", start_errs);
endtask

task automatic flush_in_flight();
  int start_errs;
  int start_outs;
  start_errs = err_count;
  @(negedge clk_i);
  out_ready_i = 1'b0;
  push_op(make_req($urandom, $urandom, OP_MIN, FP8, 1'b1, 4'b1111));
  push_op(make_req($urandom, $urandom, OP_SGNJ, FP32, 1'b0, 4'b0001));
  @(negedge clk_i);
  in_valid_i = 1'b0;
  flush_i    = 1'b1;
  exp_q.delete(); // Both items are dropped
  #1;
  if (busy_o !== 1'b1) begin
    $display("error at %0t: busy_o is %b before the flush, expected 1", $time, busy_o);
    err_count++;
  end
  @(negedge clk_i);
  flush_i     = 1'b0;
  out_ready_i = 1'b1;
  #1;
  if (busy_o !== 1'b0) begin
    $display("error at %0t: busy_o is %b, expected 0", $time, busy_o);
    err_count++;
  end
  if (out_valid_o !== 1'b0) begin
    $display("error at %0t: out_valid_o is %b, expected 0", $time, out_valid_o);
    err_count++;
  end
  start_outs = out_count;
  repeat (4) @(negedge clk_i);
  if (out_count != start_outs) begin
    $display("flushed operations still produced %0d outputs", out_count - start_outs);
    err_count++;
  end
  push_op(make_req($urandom, $urandom, OP_SGNJX, FP16, 1'b1, 4'b0011));
  idle_input();
  wait_drain();
  report_test("flush_in_flight", start_errs);
endtask

`endif

//--- testbench/tb_fpslice_top.sv
`include "fpslice_params.svh"

module tb_fpslice_top import fpslice_pkg::*; ();

  localparam int WAIT_LIMIT = 100;

  typedef struct packed {
    logic [31:0] result;
    status_t     status;
    logic [3:0]  tag;
  } expect_t;

  logic                          clk_i;
  logic                          rst_i;
  logic                          flush_i;
  slice_req_t                    req_i;
  logic                          in_valid_i;
  logic                          in_ready_o;
  logic [`FPSLICE_WIDTH-1:0]     result_o;
  status_t                       status_o;
  logic [`FPSLICE_TAG_WIDTH-1:0] tag_o;
  logic                          out_valid_o;
  logic                          out_ready_i;
  logic                          busy_o;

  expect_t    exp_q[$]; // Accepted operations whose result is still due
  int         err_count;
  int         tests_run;
  int         failed_tests;
  int         out_count;
  logic [3:0] tag_count;

  fpslice_top u_fpslice_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  always #4 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic void fmt_dims(input fp_format_e fmt, output int fw, output int ew,
                                   output int mw);
    case (fmt)
      FP16: begin
        fw = 16;
        ew = 5;
        mw = 10;
      end
      FP8: begin
        fw = 8;
        ew = 5;
        mw = 2;
      end
      default: begin
        fw = 32;
        ew = 8;
        mw = 23;
      end
    endcase
  endfunction

  // One element in the low fw bits, zero above
  function automatic logic [31:0] ref_elem(input logic [31:0] a, input logic [31:0] b,
                                           input operation_e op, input int fw, input int ew,
                                           input int mw, output logic nv);
    logic [31:0] fmask;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] qnan;
    logic        sa;
    logic        sb;
    logic        a_nan;
    logic        b_nan;
    logic        a_lt_b;
    fmask  = (fw == 32) ? 32'hffff_ffff : (32'd1 << fw) - 32'd1;
    a      = a & fmask;
    b      = b & fmask;
    sa     = a[fw-1];
    sb     = b[fw-1];
    ma     = a & (fmask >> 1);
    mb     = b & (fmask >> 1);
    a_nan  = ((ma >> mw) == (32'd1 << ew) - 32'd1) && ((a & ((32'd1 << mw) - 32'd1)) != 0);
    b_nan  = ((mb >> mw) == (32'd1 << ew) - 32'd1) && ((b & ((32'd1 << mw) - 32'd1)) != 0);
    qnan   = (((32'd1 << ew) - 32'd1) << mw) | (32'd1 << (mw - 1));
    a_lt_b = (sa != sb) ? sa : (sa ? (ma > mb) : (ma < mb)); // -0 sits below +0
    nv     = 1'b0;
    case (op)
      OP_SGNJ:  return (32'(sb) << (fw - 1)) | ma;
      OP_SGNJN: return (32'(~sb) << (fw - 1)) | ma;
      OP_SGNJX: return (32'(sa ^ sb) << (fw - 1)) | ma;
      OP_MIN, OP_MAX: begin
        nv = (a_nan && !a[mw-1]) || (b_nan && !b[mw-1]);
        if (a_nan && b_nan) return qnan;
        if (a_nan) return b;
        if (b_nan) return a;
        if (op == OP_MIN) return a_lt_b ? a : b;
        return a_lt_b ? b : a;
      end
      default: return a;
    endcase
  endfunction

  // Whole slice word, unused segments NaN-boxed
  function automatic logic [31:0] ref_slice(input slice_req_t r, output status_t st);
    int          fw;
    int          ew;
    int          mw;
    int          nlanes;
    logic [31:0] res;
    logic [31:0] e;
    logic        nv;
    fmt_dims(r.fmt, fw, ew, mw);
    nlanes = r.vectorial ? 32 / fw : 1;
    res    = '1;
    st     = '0;
    for (int i = 0; i < nlanes; i++) begin
      e = ref_elem(r.op_a >> (i * fw), r.op_b >> (i * fw), r.op, fw, ew, mw, nv);
      for (int k = 0; k < fw; k++) begin
        res[i*fw+k] = e[k];
      end
      if (nv && r.mask[i]) st.nv = 1'b1;
    end
    return res;
  endfunction

  function automatic slice_req_t make_req(input logic [31:0] a, input logic [31:0] b,
                                          input operation_e op, input fp_format_e fmt,
                                          input logic vec, input logic [3:0] mask);
    slice_req_t r;
    r.op_a      = a;
    r.op_b      = b;
    r.op        = op;
    r.fmt       = fmt;
    r.vectorial = vec;
    r.mask      = mask;
    r.tag       = '0;
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus and monitor
  // --------------------------------------------------------------------------

  // Returns on the edge that takes the request, valid stays high
  task automatic push_op(input slice_req_t r);
    int      waited;
    expect_t e;
    r.tag = tag_count;
    tag_count++;
    @(negedge clk_i);
    req_i      = r;
    in_valid_i = 1'b1;
    #1;
    waited = 0;
    while (!in_ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!in_ready_o) begin
      $display("timeout at %0t: request with tag %0d was never accepted", $time, r.tag);
      err_count++;
      in_valid_i = 1'b0;
    end else begin
      e.result = ref_slice(r, e.status);
      e.tag    = r.tag;
      exp_q.push_back(e);
    end
    @(posedge clk_i);
  endtask

  task automatic idle_input();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      #2;
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout at %0t: %0d results never came out", $time, exp_q.size());
      err_count++;
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int start_errs);
    tests_run++;
    if (err_count != start_errs) begin
      failed_tests++;
      $display("%s: FAILED with %0d errors", name, err_count - start_errs);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  always begin : out_monitor
    expect_t e;
    @(negedge clk_i);
    #1;
    if (!rst_i && !flush_i && out_valid_o && out_ready_i) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("error at %0t: output with tag %0d appeared with nothing pending",
                 $time, tag_o);
        err_count++;
      end else begin
        e = exp_q.pop_front();
        if (result_o !== e.result) begin
          $display("error at %0t: result_o is %h, expected %h", $time, result_o, e.result);
          err_count++;
        end
        if (status_o !== e.status) begin
          $display("error at %0t: status_o is %b, expected %b", $time, status_o, e.status);
          err_count++;
        end
        if (tag_o !== e.tag) begin
          $display("error at %0t: tag_o is %0d, expected %0d", $time, tag_o, e.tag);
          err_count++;
        end
      end
    end
  end

  `include "fpslice_tests.svh"

  initial begin : run
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    flush_i      = 1'b0;
    req_i        = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b1;
    err_count    = 0;
    tests_run    = 0;
    failed_tests = 0;
    out_count    = 0;
    tag_count    = '0;
    void'($urandom(32'hdc40_6f6d));
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    minmax_fp32_scalar();
    sgnj_narrow_scalar();
    vector_minmax_snan();
    stream_backpressure();
    latency_check();
    flush_in_flight();

    $display("tests run %0d, failing %0d, errors %0d", tests_run, failed_tests, err_count);
    if (failed_tests == 0 && err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- fpslice.f
+incdir+design
+incdir+testbench
design/fpslice_pkg.sv
design/fp_sgnj_minmax.sv
design/fpslice_pipe.sv
design/fpslice_lane.sv
design/fpslice_result_pack.sv
design/fpslice_top.sv
testbench/tb_fpslice_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpslice_top
FILELIST  ?= fpslice.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
